//--- project.f
+incdir+verilog
verilog/u2_rx_pkg.sv
verilog/setting_reg.sv
verilog/rx_sampler.sv
verilog/sample_fifo.sv
verilog/frame_writer.sv
verilog/u2_rx_core.sv
test/tb_clock_gen.sv
test/tb_u2_rx_core.sv

//--- test/tb_clock_gen.sv
/*
   Testbench clock and power-on reset
*/
`default_nettype none

module tb_clock_gen (
   output logic dsp_clk_o,
   output logic reset_o
);

   // 20 time unit period
   initial begin
      dsp_clk_o = 1'b0;
      forever #10 dsp_clk_o = ~dsp_clk_o;
   end

   // Reset held for two rising edges, released on a falling edge
   initial begin
      reset_o = 1'b1;
      repeat (2) @(posedge dsp_clk_o);
      @(negedge dsp_clk_o);
      reset_o = 1'b0;
   end

endmodule

`default_nettype wire

//--- test/tb_u2_rx_core.sv
/*
   Receive core testbench
   LED mux, frame format, timestamps, back-pressure and overrun
*/
`default_nettype none
`include "u2_rx_defines.svh"

module tb_u2_rx_core;

   localparam int RESET_LEN = 20;
   localparam int LED_LEN   = 60;
   localparam int FRAME_LEN = 200;
   localparam int TS_LEN    = 150;
   localparam int BP_LEN    = 600;
   localparam int OVR_LEN   = 300;
   localparam int LIMIT     = RESET_LEN + LED_LEN + FRAME_LEN + TS_LEN + BP_LEN + OVR_LEN;

   logic dsp_clk, gen_rst, tb_rst, reset_i;
   logic set_stb_i, clk_status_i, serdes_link_up_i, wr_ready_i;
   logic [7:0] set_addr_i;
   logic [31:0] set_data_i;
   logic [13:0] adc_a_i, adc_b_i;
   logic [7:0] leds_o;
   logic [31:0] wr_data_o;
   logic [2:0] wr_flags_o;
   logic wr_ready_o, overrun_o;

   logic [31:0] lfsr = 32'ha570_47b0;
   string test_name = "reset";
   int errors = 0, tests_run = 0, tests_failed = 0, test_err0 = 0, cycles = 0;
   int model_len = 0, model_decim = 0;
   logic check_ts = 1'b0, allow_ovr = 1'b0;

   // Monitor state
   logic [31:0] hist [1024];
   logic [31:0] cyc, hdr_ts;
   logic in_frame, have_prev;
   int idx, frames, err_hdrs, ovr_count;

   assign reset_i = gen_rst | tb_rst;

   tb_clock_gen clock_gen_i (.dsp_clk_o(dsp_clk), .reset_o(gen_rst));

   u2_rx_core u2_rx_core_i (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .adc_a_i(adc_a_i), .adc_b_i(adc_b_i),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .leds_o(leds_o), .wr_data_o(wr_data_o), .wr_flags_o(wr_flags_o),
      .wr_ready_o(wr_ready_o), .wr_ready_i(wr_ready_i), .overrun_o(overrun_o)
   );

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Each LED follows its status bit where the source bit is set
   function automatic logic [7:0] expected_leds(input logic [7:0] src, input logic [7:0] sw,
                                                input logic [1:0] hw);
      logic [7:0] leds;
      for (int b = 0; b < 8; b++) begin
         if (!src[b]) begin
            leds[b] = sw[b];
         end else if (b < 2) begin
            leds[b] = hw[b];
         end else begin
            leds[b] = 1'b0;
         end
      end
      return leds;
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else begin
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i = 1'b0;
   endtask

   task automatic pulse_reset();
      tb_rst = 1'b1;
      repeat (2) @(negedge dsp_clk);
      tb_rst = 1'b0;
   endtask

   // Frame length first, then run with the decimation
   task automatic start_rx(input int len, input int decim);
      model_len   = len;
      model_decim = decim;
      write_setting(`U2_SR_RX_FRAME, len);
      write_setting(`U2_SR_RX_CTRL, {23'd0, 1'b1, 8'(decim)});
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors == test_err0) begin
         $display("Test %s: passed", test_name);
      end else begin
         $display("Test %s: failed with %0d errors", test_name, errors - test_err0);
         tests_failed++;
      end
   endtask

   ////////////////////
   // ADC history and output monitor

   always @(posedge dsp_clk) begin
      if (reset_i) begin
         cyc <= '0;
      end else begin
         hist[cyc[9:0]] <= {16'($signed(adc_a_i)), 16'($signed(adc_b_i))};
         cyc <= cyc + 32'd1;
      end
   end

   always @(posedge dsp_clk) begin
      if (reset_i) begin
         in_frame = 1'b0;
         have_prev = 1'b0;
         idx = 0;
         frames = 0;
         err_hdrs = 0;
         ovr_count = 0;
      end else begin
         if (overrun_o) ovr_count++;
         if (wr_ready_o && wr_ready_i) begin
            if (!in_frame) begin
               check_val("header sop", 1, wr_flags_o[2]);
               check_val("header eop", 0, wr_flags_o[1]);
               if (!allow_ovr) check_val("header err", 0, wr_flags_o[0]);
               if (wr_flags_o[0]) err_hdrs++;
               if (check_ts && have_prev) begin
                  check_val("header time step", (model_len + 1) * (model_decim + 1),
                     wr_data_o - hdr_ts);
               end
               have_prev = 1'b1;
               hdr_ts = wr_data_o;
               in_frame = 1'b1;
               idx = 0;
            end else begin
               check_val("sample sop", 0, wr_flags_o[2]);
               check_val("sample err", 0, wr_flags_o[0]);
               check_val("sample eop", idx == model_len, wr_flags_o[1]);
               check_val("sample data",
                  hist[10'(hdr_ts + idx * (model_decim + 1))], wr_data_o);
               if (idx == model_len) begin
                  in_frame = 1'b0;
                  frames++;
               end else begin
                  idx++;
               end
            end
         end
      end
   end

   // Stalled word must not move
   a_stall_hold : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      (wr_ready_o && !wr_ready_i) |=>
         (wr_ready_o && $stable(wr_data_o) && $stable(wr_flags_o))
   ) else begin
      $display("Output word changed while stalled in test %s", test_name);
      errors++;
   end

   a_no_overrun : assert property (
      @(posedge dsp_clk) disable iff (reset_i || allow_ovr)
      !overrun_o
   ) else begin
      $display("Unexpected overrun in test %s", test_name);
      errors++;
   end

   // Run length guard
   always @(posedge dsp_clk) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("Timeout after %0d cycles in test %s", cycles, test_name);
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      logic [31:0] sw, src, r;
      int f0;
      tb_rst = 1'b0;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      adc_a_i = '0;
      adc_b_i = '0;
      clk_status_i = 1'b0;
      serdes_link_up_i = 1'b0;
      wr_ready_i = 1'b1;
      @(negedge gen_rst);
      @(negedge dsp_clk);

      begin_test("reset");
      check_val("wr_ready_o", 0, wr_ready_o);
      check_val("overrun_o", 0, overrun_o);
      check_val("leds_o", 0, leds_o);
      end_test();

      begin_test("led_mux");
      sw = '0;
      src = '0;
      for (int i = 0; i < 12; i++) begin
         rand_bits(8, r);
         if (i[0]) sw = r;
         else src = r;
         rand_bits(2, r);
         {clk_status_i, serdes_link_up_i} = r[1:0];
         write_setting(i[0] ? `U2_SR_LED : `U2_SR_LED_SRC, i[0] ? sw : src);
         check_val("leds_o",
            expected_leds(src[7:0], sw[7:0], {clk_status_i, serdes_link_up_i}),
            leds_o);
      end
      end_test();

      begin_test("frame_format");
      adc_a_i = 14'h2abc;
      adc_b_i = 14'h0123;
      check_ts = 1'b1;
      pulse_reset();
      start_rx(3, 2);
      while (frames < 5) @(negedge dsp_clk);
      end_test();

      begin_test("timestamps");
      adc_a_i = 14'h1f00;
      adc_b_i = 14'h3ffe;
      pulse_reset();
      start_rx(0, 5);
      while (frames < 6) @(negedge dsp_clk);
      end_test();

      begin_test("back_pressure");
      pulse_reset();
      start_rx(4, 12);
      while (frames < 4) begin
         rand_bits(1, r);
         wr_ready_i = r[0];
         rand_bits(28, r);
         {adc_a_i, adc_b_i} = r[27:0];
         @(negedge dsp_clk);
      end
      wr_ready_i = 1'b1;
      end_test();

      begin_test("overrun");
      adc_a_i = 14'h0555;
      adc_b_i = 14'h2aaa;
      check_ts = 1'b0;
      allow_ovr = 1'b1;
      wr_ready_i = 1'b0;
      pulse_reset();
      start_rx(2, 0);
      repeat (40) @(negedge dsp_clk);
      wr_ready_i = 1'b1;
      f0 = frames;
      while (err_hdrs == 0 || frames < f0 + 4) @(negedge dsp_clk);
      assert (ovr_count > 0) else begin
         $display("No overrun pulse seen in test %s", test_name);
         errors++;
      end
      write_setting(`U2_SR_RX_CTRL, 0);
      pulse_reset();
      allow_ovr = 1'b0;
      end_test();

      $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/frame_writer.sv
/*
   Frame writer
   Turns FIFO samples into header plus sample frames on the ready paired port
*/
`default_nettype none

module frame_writer (
   input  wire                         dsp_clk,
   input  wire                         reset_i,
   input  wire u2_rx_pkg::frame_len_t  frame_len_i,
   input  wire u2_rx_pkg::rx_entry_t   head_i,
   input  wire                         not_empty_i,
   input  wire                         overrun_i,
   output logic                        pop_o,
   output logic [31:0]                 wr_data_o,
   output u2_rx_pkg::wr_flags_t        wr_flags_o,
   output logic                        wr_ready_o,
   input  wire                         wr_ready_i
);

   import u2_rx_pkg::*;

   typedef enum logic {
      ST_HEADER,
      ST_SAMPLES
   } state_t;

   state_t      state;
   frame_len_t  sample_cnt;
   logic        err_q;
   logic        load;
   logic        hdr_load;
   logic        last_sample;

   // Output slot is free when empty or when its word leaves this cycle
   assign load        = !wr_ready_o || wr_ready_i;
   assign hdr_load    = load && not_empty_i && (state == ST_HEADER);
   assign last_sample = (sample_cnt == frame_len_i);

   // Each sample word loaded takes one entry off the FIFO
   assign pop_o = load && not_empty_i && (state == ST_SAMPLES);

   ////////////////////
   // Drop tracking

   // Sticky until a header picks it up
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= (err_q && !hdr_load) || overrun_i;
      end
   end

   ////////////////////
   // Frame FSM and output register

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         state      <= ST_HEADER;
         sample_cnt <= '0;
         wr_ready_o <= 1'b0;
         wr_flags_o <= '0;
      end else if (load) begin
         wr_ready_o <= not_empty_i;
         if (not_empty_i) begin
            case (state)
               ST_HEADER: begin
                  // Header holds the time of the first sample, no pop
                  wr_flags_o <= '{sop: 1'b1, eop: 1'b0, err: err_q};
                  sample_cnt <= '0;
                  state      <= ST_SAMPLES;
               end
               ST_SAMPLES: begin
                  wr_flags_o <= '{sop: 1'b0, eop: last_sample, err: 1'b0};
                  if (last_sample) begin
                     state <= ST_HEADER;
                  end else begin
                     sample_cnt <= sample_cnt + 8'd1;
                  end
               end
               default: state <= ST_HEADER;
            endcase
         end
      end
   end

   // Data word carries no reset
   always_ff @(posedge dsp_clk) begin
      if (load && not_empty_i) begin
         if (state == ST_HEADER) begin
            wr_data_o <= head_i.ts;
         end else begin
            wr_data_o <= head_i.sample;
         end
      end
   end

   // Stalled words stay put until accepted
   a_hold_stalled : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      (wr_ready_o && !wr_ready_i) |=>
         (wr_ready_o && $stable(wr_data_o) && $stable(wr_flags_o))
   ) else $error("frame_writer: output changed while stalled");

endmodule

`default_nettype wire

//--- verilog/rx_sampler.sv
/*
   Receive sampler
   Master time counter, decimation strobe and timestamped sample capture
*/
`default_nettype none
`include "u2_rx_defines.svh"

module rx_sampler (
   input  wire                       dsp_clk,
   input  wire                       reset_i,
   input  wire u2_rx_pkg::rx_ctrl_t  ctrl_i,
   input  wire  [`U2_ADC_W-1:0]      adc_a_i,
   input  wire  [`U2_ADC_W-1:0]      adc_b_i,
   output logic                      push_o,
   output u2_rx_pkg::rx_entry_t      entry_o
);

   import u2_rx_pkg::*;

   localparam int EXT_W = 16 - `U2_ADC_W;

   logic [31:0] master_time;
   logic [7:0]  decim_cnt;
   logic        strobe;
   sample_t     sample_ext;

   ////////////////////
   // Master time

   // Free running from reset, one count per cycle
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         master_time <= '0;
      end else begin
         master_time <= master_time + 32'd1;
      end
   end

   ////////////////////
   // Decimation

   // Capture whenever the down counter sits at zero
   assign strobe = ctrl_i.run && (decim_cnt == 8'd0);

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         decim_cnt <= '0;
      end else if (!ctrl_i.run) begin
         // Restart so the first capture lands right when run rises
         decim_cnt <= '0;
      end else if (decim_cnt == 8'd0) begin
         decim_cnt <= ctrl_i.decim;
      end else begin
         decim_cnt <= decim_cnt - 8'd1;
      end
   end

   ////////////////////
   // Sample capture

   // Sign extend both channels to 16 bits
   assign sample_ext.a = {{EXT_W{adc_a_i[`U2_ADC_W-1]}}, adc_a_i};
   assign sample_ext.b = {{EXT_W{adc_b_i[`U2_ADC_W-1]}}, adc_b_i};

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         push_o <= 1'b0;
      end else begin
         push_o <= strobe;
      end
   end

   // Timestamp is the count seen at the capture edge
   always_ff @(posedge dsp_clk) begin
      if (strobe) begin
         entry_o.ts     <= master_time;
         entry_o.sample <= sample_ext;
      end
   end

   // Captures within one run sit decim+1 cycles apart
   // entry_o still holds the previous capture at this point
   a_decim_spacing : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      (strobe && $past(ctrl_i.run)) |->
         (master_time - entry_o.ts == {24'd0, ctrl_i.decim} + 32'd1)
   ) else $error("rx_sampler: capture spacing differs from decim+1");

endmodule

`default_nettype wire

//--- verilog/sample_fifo.sv
/*
   Sample FIFO
   Show-ahead circular buffer of timestamped samples; pushes while full are dropped
*/
`default_nettype none
`include "u2_rx_defines.svh"

module sample_fifo (
   input  wire                        dsp_clk,
   input  wire                        reset_i,
   input  wire                        push_i,
   input  wire u2_rx_pkg::rx_entry_t  entry_i,
   input  wire                        pop_i,
   output u2_rx_pkg::rx_entry_t       head_o,
   output logic                       not_empty_o,
   output logic                       overrun_o
);

   import u2_rx_pkg::*;

   localparam int AW    = `U2_FIFO_AW;
   localparam int DEPTH = 1 << AW;

   rx_entry_t      mem [DEPTH];
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [AW:0]    count;
   logic           full;
   logic           push_ok;

   // Count reaches DEPTH exactly when the top bit is set
   assign full        = count[AW];
   assign not_empty_o = (count != '0);

   // A push into a full buffer is lost and flagged that same cycle
   assign push_ok   = push_i && !full;
   assign overrun_o = push_i && full;

   ////////////////////
   // Storage

   always_ff @(posedge dsp_clk) begin
      if (push_ok) begin
         mem[wr_ptr] <= entry_i;
      end
   end

   // Head is read straight out of the array
   assign head_o = mem[rd_ptr];

   ////////////////////
   // Pointers and count

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_ok, pop_i})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // The frame writer must never pop an empty buffer
   a_no_pop_empty : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      pop_i |-> not_empty_o
   ) else $error("sample_fifo: pop while empty");

endmodule

`default_nettype wire

//--- verilog/setting_reg.sv
/*
   Setting register
   Loads the low bits of the settings bus word when its address is strobed
*/
`default_nettype none
`include "u2_rx_defines.svh"

module setting_reg #(
   parameter int  ADDR      = 0,
   parameter type payload_t = logic [31:0]
) (
   input  wire         dsp_clk,
   input  wire         reset_i,
   input  wire         set_stb_i,
   input  wire  [7:0]  set_addr_i,
   input  wire  [31:0] set_data_i,
   output payload_t    value_o
);

   localparam int PAYLOAD_W = $bits(payload_t);
   localparam logic [31:0] RESET_WORD = `U2_SR_RESET_VAL;

   logic hit;

   // Address decode
   assign hit = set_stb_i && (set_addr_i == 8'(ADDR));

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         value_o <= payload_t'(RESET_WORD[PAYLOAD_W-1:0]);
      end else if (hit) begin
         // Only the low bits are kept
         value_o <= payload_t'(set_data_i[PAYLOAD_W-1:0]);
      end
   end

endmodule

`default_nettype wire

//--- verilog/u2_rx_core.sv
/*
   Receive core top level
   Setting registers, LED source mux and the sampler, FIFO and frame writer chain
*/
`default_nettype none
`include "u2_rx_defines.svh"

module u2_rx_core (
   input  wire                    dsp_clk,
   input  wire                    reset_i,
   input  wire                    set_stb_i,
   input  wire  [7:0]             set_addr_i,
   input  wire  [31:0]            set_data_i,
   input  wire  [`U2_ADC_W-1:0]   adc_a_i,
   input  wire  [`U2_ADC_W-1:0]   adc_b_i,
   input  wire                    clk_status_i,
   input  wire                    serdes_link_up_i,
   output u2_rx_pkg::led_t        leds_o,
   output logic [31:0]            wr_data_o,
   output u2_rx_pkg::wr_flags_t   wr_flags_o,
   output logic                   wr_ready_o,
   input  wire                    wr_ready_i,
   output logic                   overrun_o
);

   import u2_rx_pkg::*;

   led_t        led_sw;
   led_t        led_src;
   led_t        led_hw;
   rx_ctrl_t    rx_ctrl;
   frame_len_t  frame_len;

   logic        push;
   rx_entry_t   entry;
   rx_entry_t   head;
   logic        not_empty;
   logic        pop;

   ////////////////////
   // Setting registers

   setting_reg #(.ADDR(`U2_SR_LED), .payload_t(led_t)) sr_led (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(led_sw)
   );

   setting_reg #(.ADDR(`U2_SR_LED_SRC), .payload_t(led_t)) sr_led_src (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(led_src)
   );

   setting_reg #(.ADDR(`U2_SR_RX_CTRL), .payload_t(rx_ctrl_t)) sr_rx_ctrl (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(rx_ctrl)
   );

   setting_reg #(.ADDR(`U2_SR_RX_FRAME), .payload_t(frame_len_t)) sr_rx_frame (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(frame_len)
   );

   ////////////////////
   // LEDs

   // Status bits in the two lowest positions
   assign led_hw = {{(`U2_LED_W-2){1'b0}}, clk_status_i, serdes_link_up_i};

   // Source bit 1 picks hardware status, 0 picks software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   ////////////////////
   // Receive path

   rx_sampler rx_sampler_i (
      .dsp_clk(dsp_clk),
      .reset_i(reset_i),
      .ctrl_i(rx_ctrl),
      .adc_a_i(adc_a_i),
      .adc_b_i(adc_b_i),
      .push_o(push),
      .entry_o(entry)
   );

   sample_fifo sample_fifo_i (
      .dsp_clk(dsp_clk),
      .reset_i(reset_i),
      .push_i(push),
      .entry_i(entry),
      .pop_i(pop),
      .head_o(head),
      .not_empty_o(not_empty),
      .overrun_o(overrun_o)
   );

   frame_writer frame_writer_i (
      .dsp_clk(dsp_clk),
      .reset_i(reset_i),
      .frame_len_i(frame_len),
      .head_i(head),
      .not_empty_i(not_empty),
      .overrun_i(overrun_o),
      .pop_o(pop),
      .wr_data_o(wr_data_o),
      .wr_flags_o(wr_flags_o),
      .wr_ready_o(wr_ready_o),
      .wr_ready_i(wr_ready_i)
   );

endmodule

`default_nettype wire

//--- verilog/u2_rx_defines.svh
/*
   Receive core constants
   Widths, FIFO depth, setting register addresses and reset value
*/
`ifndef U2_RX_DEFINES_SVH
`define U2_RX_DEFINES_SVH

// ADC sample width
`define U2_ADC_W 14

// log2 of the sample FIFO depth (16 entries)
`define U2_FIFO_AW 4

// Number of front panel LEDs
`define U2_LED_W 8

////////////////////
// Setting bus addresses

`define U2_SR_LED 8'd3
`define U2_SR_LED_SRC 8'd8
`define U2_SR_RX_CTRL 8'd9
`define U2_SR_RX_FRAME 8'd10

// Value every setting register takes on reset
`define U2_SR_RESET_VAL 32'h0000_0000

`endif

//--- verilog/u2_rx_pkg.sv
/*
   Receive core types
   Sample, FIFO entry, control word and frame flag layouts
*/
`default_nettype none
`include "u2_rx_defines.svh"

package u2_rx_pkg;

   // Channel A in the upper half, channel B in the lower half
   typedef struct packed {
      logic [15:0] a;
      logic [15:0] b;
   } sample_t;

   // One FIFO entry, timestamp first
   typedef struct packed {
      logic [31:0] ts;
      sample_t     sample;
   } rx_entry_t;

   ////////////////////
   // Setting payloads

   // Low bits of set_data; one sample every decim+1 cycles
   typedef struct packed {
      logic       run;
      logic [7:0] decim;
   } rx_ctrl_t;

   // Samples per frame minus one
   typedef logic [7:0] frame_len_t;

   typedef logic [`U2_LED_W-1:0] led_t;

   ////////////////////
   // Output port flags

   // err only ever rides on a header
   typedef struct packed {
      logic sop;
      logic eop;
      logic err;
   } wr_flags_t;

endpackage

`default_nettype wire
